//--- common/mbus_pkg.sv
// Shared widths, addresses and frame phases for the ring bus master node
// Addresses are fixed, there is no run-time address enumeration
// Only the master's own address and the broadcast address are decoded

package mbus_pkg;

    //**********************************************************************
    // Frame field widths
    //**********************************************************************
    localparam int ADDR_BITS  = 8;
    localparam int DATA_BITS  = 32;
    localparam int COUNT_BITS = 16;
    // Bit position within a field, wide enough for a full word
    localparam int POS_BITS   = 5;
    // Address, first pend bit and first word, loaded together at START
    localparam int TX_SREG_BITS = ADDR_BITS + 1 + DATA_BITS;

    typedef logic [ADDR_BITS-1:0]    addr_t;
    typedef logic [DATA_BITS-1:0]    data_t;
    typedef logic [COUNT_BITS-1:0]   bits_count_t;
    typedef logic [POS_BITS-1:0]     bit_pos_t;
    typedef logic [TX_SREG_BITS-1:0] tx_sreg_t;

    //**********************************************************************
    // Addresses
    //**********************************************************************
    localparam addr_t MASTER_ADDR    = 8'h01;
    localparam addr_t BROADCAST_ADDR = 8'hFF;

    // Frame phases, in the order they appear on the bus
    typedef enum logic [2:0] {
        IDLE,
        START,
        ADDR,
        PEND,
        DATA,
        END
    } frame_phase_e;

endpackage

//--- master_ctrl/mbus_master_ctrl.sv
// Bus clock and frame sequencer of the master node
// One bit takes two CLK_EXT cycles, cout rises when din is sampled
// din is used unsynchronized, it must be clean to CLK_EXT
// A zero num_bits_threshold turns the watchdog off
`timescale 1ns/10ps

module mbus_master_ctrl (
    input  logic                   CLK_EXT,
    input  logic                   RESETn_local,
    input  logic                   din,
    input  logic                   tx_req,
    input  mbus_pkg::bits_count_t  num_bits_threshold,
    output logic                   cout,
    output mbus_pkg::frame_phase_e phase,
    output logic                   bit_shift,
    output logic                   bit_sample,
    output logic                   frame_is_rx,
    output logic                   word_done,
    output logic                   frame_end,
    output logic                   frame_abort,
    output logic                   mbus_busy
);

    // Internal half of the bit, low half first
    logic                   half_q;
    // Last sampled pend bit, decides if another word follows
    logic                   pend_q;
    mbus_pkg::bit_pos_t     bit_cnt;
    mbus_pkg::bits_count_t  frame_bits;
    mbus_pkg::bits_count_t  frame_bits_inc;
    logic                   addr_last;
    logic                   data_last;
    logic                   wd_expired;
    mbus_pkg::frame_phase_e phase_nxt;

    //**********************************************************************
    // Bit strobes
    //**********************************************************************
    assign mbus_busy  = (phase != mbus_pkg::IDLE);
    assign bit_shift  = mbus_busy & ~half_q;
    assign bit_sample = mbus_busy & half_q;

    assign addr_last = (bit_cnt == mbus_pkg::bit_pos_t'(mbus_pkg::ADDR_BITS - 1));
    assign data_last = (bit_cnt == mbus_pkg::bit_pos_t'(mbus_pkg::DATA_BITS - 1));
    // Last bit of a word, din holds that bit in this cycle
    assign word_done = bit_sample & (phase == mbus_pkg::DATA) & data_last;

    // Watchdog counts every sampled bit from START on
    assign frame_bits_inc = frame_bits + 1'b1;
    assign wd_expired = bit_sample & (num_bits_threshold != '0) &
                        (frame_bits_inc >= num_bits_threshold) &
                        (phase != mbus_pkg::END);

    //**********************************************************************
    // Phase sequencing
    //**********************************************************************
    always_comb begin
        phase_nxt = phase;
        case (phase)
            // A low din is a member start and wins over tx_req
            mbus_pkg::IDLE: begin
                if (!din || tx_req) begin
                    phase_nxt = mbus_pkg::START;
                end
            end
            mbus_pkg::START: begin
                if (bit_sample) begin
                    phase_nxt = mbus_pkg::ADDR;
                end
            end
            mbus_pkg::ADDR: begin
                if (bit_sample && addr_last) begin
                    phase_nxt = mbus_pkg::PEND;
                end
            end
            mbus_pkg::PEND: begin
                if (bit_sample) begin
                    phase_nxt = mbus_pkg::DATA;
                end
            end
            mbus_pkg::DATA: begin
                if (bit_sample && data_last) begin
                    phase_nxt = pend_q ? mbus_pkg::PEND : mbus_pkg::END;
                end
            end
            mbus_pkg::END: begin
                if (bit_sample) begin
                    phase_nxt = mbus_pkg::IDLE;
                end
            end
            default: phase_nxt = mbus_pkg::IDLE;
        endcase
        // Runaway frame, cut it short
        if (wd_expired) begin
            phase_nxt = mbus_pkg::END;
        end
    end

    always_ff @(posedge CLK_EXT or negedge RESETn_local) begin
        if (!RESETn_local) begin
            phase       <= mbus_pkg::IDLE;
            half_q      <= 1'b0;
            cout        <= 1'b1;
            frame_is_rx <= 1'b0;
            pend_q      <= 1'b0;
            bit_cnt     <= '0;
            frame_bits  <= '0;
            frame_end   <= 1'b0;
            frame_abort <= 1'b0;
        end else begin
            phase       <= phase_nxt;
            // Both pulses fall on the first cycle of END
            frame_end   <= (phase_nxt == mbus_pkg::END) && (phase != mbus_pkg::END);
            frame_abort <= wd_expired;
            // cout follows the half one cycle late, so the line settles first
            cout        <= mbus_busy ? half_q : 1'b1;
            if (phase_nxt == mbus_pkg::IDLE) begin
                frame_is_rx <= 1'b0;
            end else if (phase == mbus_pkg::IDLE) begin
                frame_is_rx <= !din;
            end
            if (phase == mbus_pkg::IDLE) begin
                half_q     <= 1'b0;
                bit_cnt    <= '0;
                frame_bits <= '0;
            end else begin
                half_q <= ~half_q;
                if (bit_sample) begin
                    frame_bits <= frame_bits_inc;
                    // In own frames din is the echo of the sent pend bit
                    if (phase == mbus_pkg::PEND) begin
                        pend_q <= din;
                    end
                    if (phase_nxt != phase) begin
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- node/mbus_tx_shifter.sv
// Transmit shifter of the master node
// tx_data and tx_pend are taken in the cycle tx_ack is high
// Results hold until tx_resp_ack, the shifter is idle in member frames
`timescale 1ns/10ps

module mbus_tx_shifter (
    input  logic                   CLK_EXT,
    input  logic                   RESETn_local,
    input  mbus_pkg::frame_phase_e phase,
    input  logic                   bit_shift,
    input  logic                   bit_sample,
    input  logic                   frame_is_rx,
    input  logic                   frame_end,
    input  logic                   frame_abort,
    input  logic                   din,
    input  mbus_pkg::addr_t        tx_addr,
    input  mbus_pkg::data_t        tx_data,
    input  logic                   tx_pend,
    input  logic                   tx_resp_ack,
    output logic                   tx_bit,
    output logic                   tx_ack,
    output logic                   tx_succ,
    output logic                   tx_fail
);

    mbus_pkg::tx_sreg_t sreg;
    // First word still sits in sreg behind the address
    logic               first_q;
    logic               mismatch_q;
    logic               own;
    logic               load_first;
    logic               load_next;
    logic               next_bit;

    assign own        = ~frame_is_rx;
    assign load_first = own & bit_shift & (phase == mbus_pkg::START);
    // Later words are fetched at the low half of their pend bit
    assign load_next  = own & bit_shift & (phase == mbus_pkg::PEND) & ~first_q;
    assign tx_ack     = load_first | load_next;

    // Bit that goes onto the line at this bit_shift
    always_comb begin
        case (phase)
            mbus_pkg::START: next_bit = 1'b0;
            mbus_pkg::ADDR:  next_bit = sreg[mbus_pkg::TX_SREG_BITS-1];
            mbus_pkg::PEND:  next_bit = first_q ? sreg[mbus_pkg::TX_SREG_BITS-1] : tx_pend;
            mbus_pkg::DATA:  next_bit = sreg[mbus_pkg::TX_SREG_BITS-1];
            default:         next_bit = 1'b1;
        endcase
    end

    //**********************************************************************
    // Shift register, MSB first
    //**********************************************************************
    always_ff @(posedge CLK_EXT) begin
        if (load_first) begin
            sreg <= {tx_addr, tx_pend, tx_data};
        end else if (load_next) begin
            sreg <= {tx_data, {(mbus_pkg::ADDR_BITS + 1){1'b0}}};
        end else if (own && bit_shift) begin
            sreg <= sreg << 1;
        end
    end

    always_ff @(posedge CLK_EXT or negedge RESETn_local) begin
        if (!RESETn_local) begin
            tx_bit     <= 1'b1;
            first_q    <= 1'b0;
            mismatch_q <= 1'b0;
            tx_succ    <= 1'b0;
            tx_fail    <= 1'b0;
        end else begin
            if (own && bit_shift) begin
                tx_bit <= next_bit;
            end else if (frame_is_rx) begin
                tx_bit <= 1'b1;
            end
            if (load_first) begin
                first_q <= 1'b1;
            end else if (own && bit_shift && phase == mbus_pkg::PEND) begin
                first_q <= 1'b0;
            end
            // Echo check, a broken ring shows up as a flipped bit
            if (load_first) begin
                mismatch_q <= 1'b0;
            end else if (own && bit_sample && (din != tx_bit)) begin
                mismatch_q <= 1'b1;
            end
            // Frame result
            if (tx_resp_ack) begin
                tx_succ <= 1'b0;
                tx_fail <= 1'b0;
            end else if (own && frame_abort) begin
                tx_fail <= 1'b1;
            end else if (own && frame_end) begin
                tx_succ <= ~mismatch_q;
                tx_fail <= mismatch_q;
            end
        end
    end

endmodule

//--- node/mbus_rx_decoder.sv
// Receive decoder of the master node
// Accepts member frames to the master address or to broadcast
// A word that arrives while rx_req is still high is dropped with rx_fail
`timescale 1ns/10ps

module mbus_rx_decoder (
    input  logic                   CLK_EXT,
    input  logic                   RESETn_local,
    input  mbus_pkg::frame_phase_e phase,
    input  logic                   bit_sample,
    input  logic                   frame_is_rx,
    input  logic                   word_done,
    input  logic                   frame_abort,
    input  logic                   din,
    input  logic                   rx_ack,
    output mbus_pkg::addr_t        rx_addr,
    output mbus_pkg::data_t        rx_data,
    output logic                   rx_pend,
    output logic                   rx_broadcast,
    output logic                   rx_req,
    output logic                   rx_fail
);

    mbus_pkg::addr_t addr_sr;
    mbus_pkg::data_t data_sr;
    // Pend bit in front of the word being received
    logic            pend_sr;
    logic            rx_sample;
    logic            is_bcast;
    logic            addr_match;
    logic            word_take;
    logic            word_load;

    assign rx_sample  = frame_is_rx & bit_sample;

    // addr_sr is stable from the end of ADDR until the next frame
    assign is_bcast   = (addr_sr == mbus_pkg::BROADCAST_ADDR);
    assign addr_match = (addr_sr == mbus_pkg::MASTER_ADDR) | is_bcast;
    assign word_take  = word_done & frame_is_rx & addr_match;
    // Held word is replaced only once it has been acknowledged
    assign word_load  = word_take & (~rx_req | rx_ack);

    //**********************************************************************
    // Deserializer and held word
    //**********************************************************************
    always_ff @(posedge CLK_EXT) begin
        if (rx_sample) begin
            case (phase)
                mbus_pkg::ADDR: addr_sr <= {addr_sr[mbus_pkg::ADDR_BITS-2:0], din};
                mbus_pkg::PEND: pend_sr <= din;
                mbus_pkg::DATA: data_sr <= {data_sr[mbus_pkg::DATA_BITS-2:0], din};
                default: ;
            endcase
        end
        // Last data bit comes straight from din
        if (word_load) begin
            rx_addr <= addr_sr;
            rx_data <= {data_sr[mbus_pkg::DATA_BITS-2:0], din};
            rx_pend <= pend_sr;
        end
    end

    //**********************************************************************
    // Receive handshake
    //**********************************************************************
    always_ff @(posedge CLK_EXT or negedge RESETn_local) begin
        if (!RESETn_local) begin
            rx_req       <= 1'b0;
            rx_fail      <= 1'b0;
            rx_broadcast <= 1'b0;
        end else begin
            if (word_load) begin
                rx_req       <= 1'b1;
                rx_broadcast <= is_bcast;
            end else if (rx_ack) begin
                rx_req <= 1'b0;
            end
            // Overrun or aborted member frame, one cycle pulse
            rx_fail <= (word_take & rx_req & ~rx_ack) | (frame_abort & frame_is_rx);
        end
    end

endmodule

//--- logic/mbus_master_node.sv
// Top level of the ring bus master node
// mbc_reset is a soft reset, active high, merged with the external reset
// dout forwards din combinationally while a member frame runs
`timescale 1ns/10ps

module mbus_master_node (
    input  logic                  CLK_EXT,
    input  logic                  RESETn_local,
    input  logic                  mbc_reset,
    input  logic                  din,
    input  mbus_pkg::addr_t       tx_addr,
    input  mbus_pkg::data_t       tx_data,
    input  logic                  tx_pend,
    input  logic                  tx_req,
    input  logic                  tx_resp_ack,
    input  logic                  rx_ack,
    input  logic                  rx_ack_bcast,
    input  mbus_pkg::bits_count_t num_bits_threshold,
    output logic                  cout,
    output logic                  dout,
    output logic                  tx_ack,
    output logic                  tx_succ,
    output logic                  tx_fail,
    output mbus_pkg::addr_t       rx_addr,
    output mbus_pkg::data_t       rx_data,
    output logic                  rx_pend,
    output logic                  rx_req,
    output logic                  rx_broadcast,
    output logic                  rx_fail,
    output logic                  mbc_in_fwd,
    output logic                  mbus_busy
);

    logic                   core_resetn;
    logic                   rx_ack_merged;
    mbus_pkg::frame_phase_e phase;
    logic                   bit_shift;
    logic                   bit_sample;
    logic                   frame_is_rx;
    logic                   word_done;
    logic                   frame_end;
    logic                   frame_abort;
    logic                   tx_bit;

    // Either reset clears the whole core
    assign core_resetn   = RESETn_local & ~mbc_reset;
    // Broadcast words may be acknowledged on their own strobe
    assign rx_ack_merged = rx_ack | (rx_broadcast & rx_ack_bcast);

    //**********************************************************************
    // Line output
    //**********************************************************************
    assign mbc_in_fwd = frame_is_rx;
    assign dout       = frame_is_rx ? din : tx_bit;

    mbus_master_ctrl i_mbus_master_ctrl (
        .CLK_EXT            (CLK_EXT),
        .RESETn_local       (core_resetn),
        .din                (din),
        .tx_req             (tx_req),
        .num_bits_threshold (num_bits_threshold),
        .cout               (cout),
        .phase              (phase),
        .bit_shift          (bit_shift),
        .bit_sample         (bit_sample),
        .frame_is_rx        (frame_is_rx),
        .word_done          (word_done),
        .frame_end          (frame_end),
        .frame_abort        (frame_abort),
        .mbus_busy          (mbus_busy)
    );

    mbus_tx_shifter i_mbus_tx_shifter (
        .CLK_EXT      (CLK_EXT),
        .RESETn_local (core_resetn),
        .phase        (phase),
        .bit_shift    (bit_shift),
        .bit_sample   (bit_sample),
        .frame_is_rx  (frame_is_rx),
        .frame_end    (frame_end),
        .frame_abort  (frame_abort),
        .din          (din),
        .tx_addr      (tx_addr),
        .tx_data      (tx_data),
        .tx_pend      (tx_pend),
        .tx_resp_ack  (tx_resp_ack),
        .tx_bit       (tx_bit),
        .tx_ack       (tx_ack),
        .tx_succ      (tx_succ),
        .tx_fail      (tx_fail)
    );

    mbus_rx_decoder i_mbus_rx_decoder (
        .CLK_EXT      (CLK_EXT),
        .RESETn_local (core_resetn),
        .phase        (phase),
        .bit_sample   (bit_sample),
        .frame_is_rx  (frame_is_rx),
        .word_done    (word_done),
        .frame_abort  (frame_abort),
        .din          (din),
        .rx_ack       (rx_ack_merged),
        .rx_addr      (rx_addr),
        .rx_data      (rx_data),
        .rx_pend      (rx_pend),
        .rx_broadcast (rx_broadcast),
        .rx_req       (rx_req),
        .rx_fail      (rx_fail)
    );

endmodule

//--- verification/mbus_master_node_props.sv
// Concurrent checks bound to the master node top level
// All checks are off while either reset is active
`timescale 1ns/10ps

module mbus_master_node_props (
    input  logic CLK_EXT,
    input  logic RESETn_local,
    input  logic mbc_reset,
    input  logic din,
    input  logic cout,
    input  logic mbus_busy,
    input  logic tx_ack,
    input  logic tx_succ,
    input  logic tx_fail,
    input  logic rx_req,
    input  logic rx_ack,
    input  logic rx_ack_bcast,
    input  logic rx_broadcast
);

    // Member frame started by a low din while the bus is idle
    logic member_frame;

    always_ff @(posedge CLK_EXT or negedge RESETn_local) begin
        if (!RESETn_local) begin
            member_frame <= 1'b0;
        end else if (!mbus_busy) begin
            member_frame <= !din;
        end
    end

    // Bus clock parks high between frames
    a_cout_idle: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local || mbc_reset)
        !mbus_busy |-> cout)
        else $error("cout low while the bus is idle");

    // One transmit result at a time
    a_tx_result: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local || mbc_reset)
        !(tx_succ && tx_fail))
        else $error("tx_succ and tx_fail high together");

    // Receive request held until some acknowledge
    a_rx_hold: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local || mbc_reset)
        (rx_req && !rx_ack && !(rx_broadcast && rx_ack_bcast)) |=> rx_req)
        else $error("rx_req dropped without an acknowledge");

    // Shifter stays passive in member frames
    a_no_ack_fwd: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local || mbc_reset)
        (mbus_busy && member_frame) |-> !tx_ack)
        else $error("tx_ack pulsed during a member frame");

endmodule

bind mbus_master_node mbus_master_node_props i_mbus_master_node_props (.*);

//--- verification/mbus_master_node_tb.sv
// Testbench for the ring bus master node
// The testbench stands in for the ring and for a member node
// Ring mode echoes dout on din one clock late
// Member mode drives whole frames on din
// Frames hold at most 3 words
`timescale 1ns/10ps

module mbus_master_node_tb;

    localparam int FRAME_BITS_TOTAL = 585;
    localparam int TIMEOUT_NS       = (FRAME_BITS_TOTAL * 2 + 400) * 8;

    logic                  CLK_EXT;
    logic                  RESETn_local;
    logic                  mbc_reset;
    logic                  din;
    mbus_pkg::addr_t       tx_addr;
    mbus_pkg::data_t       tx_data;
    logic                  tx_pend;
    logic                  tx_req;
    logic                  tx_resp_ack;
    logic                  rx_ack       = 1'b0;
    logic                  rx_ack_bcast = 1'b0;
    mbus_pkg::bits_count_t num_bits_threshold;
    logic                  cout;
    logic                  dout;
    logic                  tx_ack;
    logic                  tx_succ;
    logic                  tx_fail;
    mbus_pkg::addr_t       rx_addr;
    mbus_pkg::data_t       rx_data;
    logic                  rx_pend;
    logic                  rx_req;
    logic                  rx_broadcast;
    logic                  rx_fail;
    logic                  mbc_in_fwd;
    logic                  mbus_busy;

    // Stimulus and bookkeeping
    string           test_name = "reset";
    logic [31:0]     rng = 32'hcd28_7e7e;
    mbus_pkg::data_t words [4];
    int              n_words    = 0;
    int              word_base  = 0;
    int              ack_cnt    = 0;
    bit              exp_q [$];
    bit              member_q [$];
    bit              exp_bit;
    logic            check_en   = 1'b0;
    logic            ring_mode  = 1'b1;
    logic            ring_din   = 1'b1;
    logic            member_din = 1'b1;
    int              flip_at    = -1;
    int              rise_cnt   = 0;
    logic            auto_ack   = 1'b1;
    logic            bcast_ack  = 1'b0;
    int              rx_cnt     = 0;
    int              fail_cnt   = 0;
    mbus_pkg::addr_t got_addr [16];
    mbus_pkg::data_t got_data [16];
    logic            got_pend [16];
    logic            got_bcast [16];

    mbus_master_node i_mbus_master_node (.*);

    //**********************************************************************
    // Clock, ring model and word source
    //**********************************************************************
    initial begin
        CLK_EXT = 1'b0;
        forever #4 CLK_EXT = ~CLK_EXT;
    end

    assign din     = ring_mode ? ring_din : member_din;
    // Word presented until its tx_ack
    // Pend set while more words follow
    assign tx_data = words[(ack_cnt - word_base) & 3];
    assign tx_pend = (ack_cnt - word_base) < (n_words - 1);

    // Echo of dout flipped once at bit flip_at
    always @(posedge CLK_EXT) begin
        #1;
        ring_din = dout ^ (flip_at == rise_cnt);
    end

    always @(negedge CLK_EXT) begin
        if (tx_ack) begin
            @(posedge CLK_EXT);
            #1;
            ack_cnt = ack_cnt + 1;
        end
    end

    always @(negedge CLK_EXT) begin
        if (rx_fail) begin
            fail_cnt = fail_cnt + 1;
        end
    end

    // Receive side captures each word and acknowledges it
    always @(negedge CLK_EXT) begin
        if (rx_ack || rx_ack_bcast) begin
            @(posedge CLK_EXT);
            #1;
            rx_ack       = 1'b0;
            rx_ack_bcast = 1'b0;
        end else if (rx_req && auto_ack) begin
            got_addr[rx_cnt % 16]  = rx_addr;
            got_data[rx_cnt % 16]  = rx_data;
            got_pend[rx_cnt % 16]  = rx_pend;
            got_bcast[rx_cnt % 16] = rx_broadcast;
            rx_cnt = rx_cnt + 1;
            @(posedge CLK_EXT);
            #1;
            if (bcast_ack) begin
                rx_ack_bcast = 1'b1;
            end else begin
                rx_ack = 1'b1;
            end
        end
    end

    //**********************************************************************
    // Helpers
    //**********************************************************************
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
            else report_fail($sformatf("Mismatch %s %s: expected %0h, actual %0h",
                                       test_name, what, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected line bits are start, address, then pend and word per word, then end
    function automatic int ref_frame(input mbus_pkg::addr_t a, input int n);
        int i;
        int b;
        exp_q.push_back(1'b0);
        for (b = mbus_pkg::ADDR_BITS - 1; b >= 0; b--) begin
            exp_q.push_back(a[b]);
        end
        for (i = 0; i < n; i++) begin
            exp_q.push_back(i < n - 1);
            for (b = mbus_pkg::DATA_BITS - 1; b >= 0; b--) begin
                exp_q.push_back(words[i][b]);
            end
        end
        exp_q.push_back(1'b1);
        return exp_q.size();
    endfunction

    // Line check at every rising cout
    always @(posedge cout) begin
        rise_cnt = rise_cnt + 1;
        if (check_en) begin
            if (exp_q.size() == 0) begin
                report_fail("dout was clocked after the expected frame had ended");
            end else begin
                exp_bit = exp_q.pop_front();
                check_val("dout", exp_bit, dout);
                // Forwarding ends in the same edge as the last bit
                if (exp_q.size() != 0) begin
                    check_val("mbc_in_fwd", !ring_mode, mbc_in_fwd);
                end
            end
        end
    end

    task automatic wait_cycle();
        @(posedge CLK_EXT);
        #1;
    endtask

    task automatic new_words(input int n);
        int i;
        for (i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            words[i] = rng;
        end
        word_base = ack_cnt;
        n_words   = n;
    endtask

    task automatic check_reset_state();
        check_val("cout", 1, cout);
        check_val("dout", 1, dout);
        check_val("tx_ack", 0, tx_ack);
        check_val("tx_succ", 0, tx_succ);
        check_val("tx_fail", 0, tx_fail);
        check_val("rx_req", 0, rx_req);
        check_val("rx_fail", 0, rx_fail);
        check_val("mbus_busy", 0, mbus_busy);
        check_val("mbc_in_fwd", 0, mbc_in_fwd);
    endtask

    // Own frame over the ring
    // A negative flip_ofs keeps the echo clean
    task automatic run_own(input string name, input int n, input int flip_ofs,
                           input bit chk, input bit exp_fail);
        test_name = name;
        new_words(n);
        tx_addr = 8'h5a;
        flip_at = (flip_ofs < 0) ? -1 : rise_cnt + flip_ofs;
        exp_q.delete();
        void'(ref_frame(tx_addr, n));
        check_en = chk;
        tx_req   = 1'b1;
        do wait_cycle(); while (!mbus_busy);
        tx_req = 1'b0;
        do wait_cycle(); while (mbus_busy);
        check_en = 1'b0;
        flip_at  = -1;
        if (chk) begin
            check_val("bits left", 0, exp_q.size());
            check_val("tx_ack count", n, ack_cnt - word_base);
        end
        check_val("tx_succ", !exp_fail, tx_succ);
        check_val("tx_fail", exp_fail, tx_fail);
        tx_resp_ack = 1'b1;
        wait_cycle();
        tx_resp_ack = 1'b0;
        check_val("tx_succ cleared", 0, tx_succ);
        check_val("tx_fail cleared", 0, tx_fail);
    endtask

    // Member frame where the member changes din after each falling cout
    task automatic run_member(input string name, input mbus_pkg::addr_t a, input int n,
                              input bit use_bcast, input bit exp_rx, input bit hold);
        int len;
        int i;
        int rx_base;
        test_name = name;
        new_words(n);
        rx_base   = rx_cnt;
        auto_ack  = !hold;
        bcast_ack = use_bcast;
        exp_q.delete();
        len = ref_frame(a, n);
        member_q = exp_q;
        ring_mode  = 1'b0;
        check_en   = 1'b1;
        member_din = 1'b0;
        do wait_cycle(); while (!mbus_busy);
        for (i = 0; i < len; i++) begin
            @(negedge cout);
            #1;
            member_din = member_q[i];
        end
        do wait_cycle(); while (mbus_busy);
        check_en  = 1'b0;
        ring_mode = 1'b1;
        repeat (4) wait_cycle();
        check_val("bits left", 0, exp_q.size());
        if (!hold) begin
            check_val("rx word count", exp_rx ? n : 0, rx_cnt - rx_base);
            for (i = 0; i < (exp_rx ? n : 0); i++) begin
                check_val("rx_addr", a, got_addr[(rx_base + i) % 16]);
                check_val("rx_data", words[i], got_data[(rx_base + i) % 16]);
                check_val("rx_pend", i < n - 1, got_pend[(rx_base + i) % 16]);
                check_val("rx_broadcast", a == 8'hFF, got_bcast[(rx_base + i) % 16]);
            end
        end
    endtask

    //**********************************************************************
    // Test sequence
    //**********************************************************************
    initial begin
        int fail_base;
        words              = '{default: '0};
        RESETn_local       = 1'b0;
        mbc_reset          = 1'b0;
        tx_addr            = '0;
        tx_req             = 1'b0;
        tx_resp_ack        = 1'b0;
        num_bits_threshold = '0;
        repeat (4) @(posedge CLK_EXT);
        #1;
        RESETn_local = 1'b1;
        check_reset_state();
        wait_cycle();

        run_own("own_single", 1, -1, 1'b1, 1'b0);
        run_own("own_three", 3, -1, 1'b1, 1'b0);
        // Bit 15 is a data bit of the first word
        run_own("own_three_corrupt", 3, 15, 1'b1, 1'b1);

        run_member("member_two", mbus_pkg::MASTER_ADDR, 2, 1'b0, 1'b1, 1'b0);
        run_member("broadcast", mbus_pkg::BROADCAST_ADDR, 1, 1'b1, 1'b1, 1'b0);
        run_member("other_addr", 8'h22, 1, 1'b0, 1'b0, 1'b0);

        // Withheld acknowledge drops the second word
        fail_base = fail_cnt;
        run_member("overrun", mbus_pkg::MASTER_ADDR, 2, 1'b0, 1'b1, 1'b1);
        check_val("rx_fail pulses", 1, fail_cnt - fail_base);
        check_val("rx_req held", 1, rx_req);
        check_val("rx_data held", words[0], rx_data);
        check_val("rx_pend held", 1, rx_pend);
        fail_base = rx_cnt;
        auto_ack  = 1'b1;
        do wait_cycle(); while (rx_cnt == fail_base);
        repeat (3) wait_cycle();
        check_val("rx_req released", 0, rx_req);

        // Watchdog cuts the frame after 20 bits
        num_bits_threshold = 16'd20;
        run_own("bit_watchdog", 1, -1, 1'b0, 1'b1);
        num_bits_threshold = '0;
        check_val("cout idle", 1, cout);

        // Soft reset in the middle of an own frame
        test_name = "soft_reset";
        new_words(2);
        tx_req = 1'b1;
        do wait_cycle(); while (!mbus_busy);
        tx_req = 1'b0;
        repeat (30) wait_cycle();
        mbc_reset = 1'b1;
        #1;
        check_reset_state();
        wait_cycle();
        mbc_reset = 1'b0;
        repeat (4) wait_cycle();
        check_reset_state();

        $display("Simulation finished: PASS");
        $finish;
    end

    // Run length bound from the summed frame lengths
    initial begin
        #(TIMEOUT_NS);
        report_fail("Watchdog expired before the tests completed");
    end

endmodule

//--- mbus_master_node.f
common/mbus_pkg.sv
master_ctrl/mbus_master_ctrl.sv
node/mbus_tx_shifter.sv
node/mbus_rx_decoder.sv
logic/mbus_master_node.sv
verification/mbus_master_node_props.sv
verification/mbus_master_node_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the master node testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f mbus_master_node.f \
    --top-module mbus_master_node_tb -o mbus_master_node_sim > build.log 2>&1 \
    && ./obj_dir/mbus_master_node_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
grep -q "^Simulation finished: PASS$" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
